/* common/mfp_pkg.sv */
// shared definitions for the 68901-style MFP
// register map, interrupt sources, timer modes and bus structs
package mfp_pkg;

	// cpu register addresses
	typedef enum logic [4:0] {
		GPIP  = 5'h00,
		AER   = 5'h01,
		DDR   = 5'h02,
		IERA  = 5'h03,
		IERB  = 5'h04,
		IPRA  = 5'h05,
		IPRB  = 5'h06,
		ISRA  = 5'h07,
		ISRB  = 5'h08,
		IMRA  = 5'h09,
		IMRB  = 5'h0A,
		VR    = 5'h0B,
		TACR  = 5'h0C,
		TBCR  = 5'h0D,
		TCDCR = 5'h0E,
		TADR  = 5'h0F,
		TBDR  = 5'h10,
		TCDR  = 5'h11,
		TDDR  = 5'h12,
		TSR   = 5'h16,
		UDR   = 5'h17
	} mfp_addr_e;

	// one cpu write cycle
	typedef struct packed {
		logic      valid;
		mfp_addr_e addr;
		logic [7:0] data;
	} mfp_wr_t;

	// interrupt controller state seen by the cpu
	typedef struct packed {
		logic [7:0]  gpip_rd;
		logic [7:0]  aer;
		logic [7:0]  ddr;
		logic [7:0]  vr;
		logic [15:0] ier;
		logic [15:0] ipr;
		logic [15:0] isr;
		logic [15:0] imr;
	} mfp_irq_regs_t;

	typedef enum logic [3:0] {
		STOP      = 4'd0,
		DELAY_4   = 4'd1,
		DELAY_10  = 4'd2,
		DELAY_16  = 4'd3,
		DELAY_50  = 4'd4,
		DELAY_64  = 4'd5,
		DELAY_100 = 4'd6,
		DELAY_200 = 4'd7,
		EVENT     = 4'd8
	} timer_mode_e;

	// interrupt source numbers
	localparam int IRQ_TIMER_A = 13;
	localparam int IRQ_TIMER_B = 8;
	localparam int IRQ_TIMER_C = 5;
	localparam int IRQ_TIMER_D = 4;
	localparam int IRQ_DMA     = 7;
	localparam int IRQ_ACIA    = 6;
	localparam int IRQ_BLITTER = 3;

endpackage

/* common/mfp_timer_if.sv */
// register strobes, readback and expiry pulse of one MFP timer
`timescale 1ns/10ps

interface mfp_timer_if;

	// from the register decoder
	logic       ctrl_we;
	logic       data_we;
	logic [7:0] wdata;

	// from the timer
	logic [3:0] ctrl_rd;
	logic [7:0] count_rd;
	logic       done;

	modport regs (
		output ctrl_we,
		output data_we,
		output wdata,
		input  ctrl_rd,
		input  count_rd
	);

	modport timer (
		input  ctrl_we,
		input  data_we,
		input  wdata,
		output ctrl_rd,
		output count_rd,
		output done
	);

	// interrupt controller only needs the expiry pulse
	modport irq (
		input  done
	);

endinterface

/* hw/mfp_regs.sv */
// MFP cpu register port
// decodes bus cycles into write strobes and muxes read data and the iack vector
`timescale 1ns/10ps

module mfp_regs
	import mfp_pkg::*;
#(
	parameter int num_timers = 4
) (
	input  logic          clk,
	input  logic          reset,
	input  logic [7:0]    din_i,
	input  logic          sel_i,
	input  logic [4:0]    addr_i,
	input  logic          ds_i,
	input  logic          rw_i,
	input  logic          iack_i,
	output logic [7:0]    dout_o,
	output mfp_wr_t       wr_o,
	mfp_timer_if.regs     timers [num_timers],
	input  mfp_irq_regs_t irq_regs_i,
	input  logic [7:0]    irq_vec_i,
	input  logic          fifo_full_i
);

	logic       wr_cycle;
	logic       rd_cycle;
	logic [7:0] udr_q;
	logic [3:0] ctrl_rd [num_timers];
	logic [7:0] count_rd [num_timers];

	assign wr_cycle = sel_i & ~ds_i & ~rw_i;
	assign rd_cycle = sel_i & ~ds_i & rw_i;

	assign wr_o = '{valid: wr_cycle, addr: mfp_addr_e'(addr_i), data: din_i};

	// per-timer strobes, C and D share one control register
	for (genvar i = 0; i < num_timers; i++) begin : g_tmr
		localparam logic [4:0] ctrl_addr = (i < 2) ? 5'(TACR + i) : 5'(TCDCR);
		localparam logic [4:0] data_addr = 5'(TADR + i);
		logic       ctrl_we;
		logic [3:0] ctrl_nib;

		assign ctrl_we  = wr_cycle && (addr_i == ctrl_addr);
		assign ctrl_nib = (i == 2) ? {1'b0, din_i[6:4]} :
		                  (i == 3) ? {1'b0, din_i[2:0]} : din_i[3:0];

		assign timers[i].ctrl_we = ctrl_we;
		assign timers[i].data_we = wr_cycle && (addr_i == data_addr);
		assign timers[i].wdata   = ctrl_we ? {4'h0, ctrl_nib} : din_i;

		assign ctrl_rd[i]  = timers[i].ctrl_rd;
		assign count_rd[i] = timers[i].count_rd;
	end

	// last transmitted byte, readable at UDR since there is no receiver
	always_ff @(posedge clk) begin
		if (reset) begin
			udr_q <= 8'h00;
		end else if (wr_cycle && addr_i == UDR) begin
			udr_q <= din_i;
		end
	end

	always_comb begin
		dout_o = 8'h00;
		if (rd_cycle) begin
			case (mfp_addr_e'(addr_i))
				GPIP:    dout_o = irq_regs_i.gpip_rd;
				AER:     dout_o = irq_regs_i.aer;
				DDR:     dout_o = irq_regs_i.ddr;
				IERA:    dout_o = irq_regs_i.ier[15:8];
				IERB:    dout_o = irq_regs_i.ier[7:0];
				IPRA:    dout_o = irq_regs_i.ipr[15:8];
				IPRB:    dout_o = irq_regs_i.ipr[7:0];
				ISRA:    dout_o = irq_regs_i.isr[15:8];
				ISRB:    dout_o = irq_regs_i.isr[7:0];
				IMRA:    dout_o = irq_regs_i.imr[15:8];
				IMRB:    dout_o = irq_regs_i.imr[7:0];
				VR:      dout_o = irq_regs_i.vr;
				TACR:    dout_o = {4'h0, ctrl_rd[0]};
				TBCR:    dout_o = {4'h0, ctrl_rd[1]};
				TCDCR:   dout_o = {ctrl_rd[2], ctrl_rd[3]};
				// tx buffer empty unless the fifo is full
				TSR:     dout_o = fifo_full_i ? 8'h00 : 8'h80;
				UDR:     dout_o = udr_q;
				default: dout_o = 8'h00;
			endcase
			for (int i = 0; i < num_timers; i++) begin
				if (addr_i == 5'(TADR + i)) begin
					dout_o = count_rd[i];
				end
			end
		end else if (iack_i) begin
			dout_o = irq_vec_i;
		end
	end

endmodule

/* hw/mfp_timer/mfp_timer.sv */
// one MFP down-counting timer
// delay mode divides the external clock, event mode counts input edges
`timescale 1ns/10ps

module mfp_timer
	import mfp_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       clk_ext_i,
	input  logic       event_i,
	mfp_timer_if.timer tmr
);

	timer_mode_e mode;
	logic [7:0]  reload;
	logic [7:0]  count;
	logic [7:0]  pre_cnt;
	logic [7:0]  pre_div;
	logic [2:0]  ext_sync;
	logic [2:0]  evt_sync;
	logic        ext_rise;
	logic        evt_rise;
	logic        is_delay;
	logic        pre_wrap;
	logic        tick;
	logic        done_q;

	function automatic logic [7:0] prescale_div(input timer_mode_e m);
		case (m)
			DELAY_4:   return 8'd4;
			DELAY_10:  return 8'd10;
			DELAY_16:  return 8'd16;
			DELAY_50:  return 8'd50;
			DELAY_64:  return 8'd64;
			DELAY_100: return 8'd100;
			DELAY_200: return 8'd200;
			default:   return 8'd1;
		endcase
	endfunction

	// two sync flops, third stage for the edge
	assign ext_rise = ext_sync[1] & ~ext_sync[2];
	assign evt_rise = evt_sync[1] & ~evt_sync[2];

	assign is_delay = (mode >= DELAY_4) && (mode <= DELAY_200);
	assign pre_div  = prescale_div(mode);
	assign pre_wrap = (pre_cnt == pre_div - 8'd1);

	always_comb begin
		tick = 1'b0;
		if (mode == EVENT) begin
			tick = evt_rise;
		end else if (is_delay) begin
			tick = ext_rise & pre_wrap;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mode     <= STOP;
			count    <= 8'h00;
			pre_cnt  <= 8'h00;
			done_q   <= 1'b0;
			ext_sync <= 3'b000;
			evt_sync <= 3'b000;
		end else begin
			ext_sync <= {ext_sync[1:0], clk_ext_i};
			evt_sync <= {evt_sync[1:0], event_i};
			done_q   <= 1'b0;

			if (is_delay && ext_rise) begin
				pre_cnt <= pre_wrap ? 8'h00 : pre_cnt + 8'd1;
			end
			if (tmr.ctrl_we) begin
				mode    <= timer_mode_e'(tmr.wdata[3:0]);
				pre_cnt <= 8'h00;
			end

			// a stopped timer loads the counter directly, 0 counts as 256
			if (tmr.data_we && mode == STOP) begin
				count <= tmr.wdata;
			end else if (tick) begin
				if (count == 8'd1) begin
					count  <= reload;
					done_q <= 1'b1;
				end else begin
					count <= count - 8'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tmr.data_we) begin
			reload <= tmr.wdata;
		end
	end

	assign tmr.ctrl_rd  = mode;
	assign tmr.count_rd = count;
	assign tmr.done     = done_q;

endmodule

/* hw/mfp_irq_ctrl.sv */
// MFP interrupt controller with the GPIP port
// edge detection, enable/pending/mask/in-service, priority and acknowledge vector
`timescale 1ns/10ps

module mfp_irq_ctrl
	import mfp_pkg::*;
#(
	parameter int num_timers = 4
) (
	input  logic          clk,
	input  logic          reset,
	input  mfp_wr_t       wr_i,
	mfp_timer_if.irq      timers [num_timers],
	input  logic          dma_irq_i,
	input  logic          acia_irq_i,
	input  logic          blitter_irq_i,
	input  logic          mono_detect_i,
	input  logic          iack_i,
	output mfp_irq_regs_t irq_regs_o,
	output logic [7:0]    irq_vec_o,
	output logic          irq_o
);

	localparam int timer_src [4] = '{IRQ_TIMER_A, IRQ_TIMER_B, IRQ_TIMER_C, IRQ_TIMER_D};

	logic [7:0]  gpip, aer, ddr, vr;
	logic [15:0] ier, ipr, isr, imr;
	logic [15:0] ipr_nxt, isr_nxt;
	logic [15:0] src_set;
	logic [15:0] pend_map, active_map;
	logic [3:0]  hi_pend, hi_active;
	logic [7:0]  gpip_in;
	logic [2:0]  periph_q1, periph_q2, periph_rise;
	logic [num_timers-1:0] timer_done;
	logic        iack_q1, iack_q2, ack;

	function automatic logic [3:0] highest_bit(input logic [15:0] map);
		logic [3:0] idx;
		idx = 4'd0;
		for (int b = 0; b < 16; b++) begin
			if (map[b]) idx = 4'(b);
		end
		return idx;
	endfunction

	for (genvar i = 0; i < num_timers; i++) begin : g_done
		assign timer_done[i] = timers[i].done;
	end

	// peripheral lines appear inverted on the port pins
	assign gpip_in = {mono_detect_i, 1'b0, ~dma_irq_i, ~acia_irq_i, ~blitter_irq_i, 3'b000};

	assign periph_rise = periph_q1 & ~periph_q2;
	assign ack         = iack_q1 & ~iack_q2;

	assign pend_map   = ipr & imr;
	assign active_map = (ipr | isr) & imr;
	assign hi_pend    = highest_bit(pend_map);
	assign hi_active  = highest_bit(active_map);

	// a higher source still in service holds off the line
	assign irq_o = (pend_map != 16'h0000) && (hi_active == hi_pend);

	always_comb begin
		src_set = 16'h0000;
		for (int i = 0; i < num_timers; i++) begin
			if (timer_done[i]) src_set[timer_src[i]] = 1'b1;
		end
		src_set[IRQ_BLITTER] = periph_rise[0];
		src_set[IRQ_ACIA]    = periph_rise[1];
		src_set[IRQ_DMA]     = periph_rise[2];
	end

	always_comb begin
		ipr_nxt = ipr;
		isr_nxt = isr;
		if (ack && pend_map != 16'h0000) begin
			ipr_nxt[hi_pend] = 1'b0;
			// software end-of-interrupt mode
			if (vr[3]) isr_nxt[hi_pend] = 1'b1;
		end
		ipr_nxt = ipr_nxt | (src_set & ier);
		if (wr_i.valid) begin
			case (wr_i.addr)
				IERA:    ipr_nxt[15:8] = ipr_nxt[15:8] & wr_i.data;
				IERB:    ipr_nxt[7:0]  = ipr_nxt[7:0] & wr_i.data;
				IPRA:    ipr_nxt[15:8] = ipr_nxt[15:8] & wr_i.data;
				IPRB:    ipr_nxt[7:0]  = ipr_nxt[7:0] & wr_i.data;
				ISRA:    isr_nxt[15:8] = isr_nxt[15:8] & wr_i.data;
				ISRB:    isr_nxt[7:0]  = isr_nxt[7:0] & wr_i.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			{gpip, aer, ddr, vr} <= '0;
			{ier, ipr, isr, imr} <= '0;
			periph_q1 <= 3'b000;
			periph_q2 <= 3'b000;
			iack_q1   <= 1'b0;
			iack_q2   <= 1'b0;
		end else begin
			periph_q1 <= {dma_irq_i, acia_irq_i, blitter_irq_i} ^ aer[5:3];
			periph_q2 <= periph_q1;
			iack_q1   <= iack_i;
			iack_q2   <= iack_q1;
			ipr       <= ipr_nxt;
			isr       <= isr_nxt;
			if (wr_i.valid) begin
				case (wr_i.addr)
					GPIP:    gpip       <= wr_i.data;
					AER:     aer        <= wr_i.data;
					DDR:     ddr        <= wr_i.data;
					IERA:    ier[15:8]  <= wr_i.data;
					IERB:    ier[7:0]   <= wr_i.data;
					IMRA:    imr[15:8]  <= wr_i.data;
					IMRB:    imr[7:0]   <= wr_i.data;
					VR:      vr         <= wr_i.data;
					default: ;
				endcase
			end
		end
	end

	// vector sampled every cycle so it is stable during the iack read
	always_ff @(posedge clk) begin
		irq_vec_o <= {vr[7:4], hi_pend};
	end

	assign irq_regs_o = '{
		gpip_rd: (gpip_in & ~ddr) | (gpip & ddr),
		aer:     aer,
		ddr:     ddr,
		vr:      vr,
		ier:     ier,
		ipr:     ipr,
		isr:     isr,
		imr:     imr
	};

endmodule

/* hw/mfp_uart_fifo.sv */
// MFP uart transmit FIFO
// filled by UDR writes, drained by strobes from the external consumer
`timescale 1ns/10ps

module mfp_uart_fifo
	import mfp_pkg::*;
#(
	parameter int fifo_addr_bits = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  mfp_wr_t    wr_i,
	input  logic       serial_strobe_i,
	output logic       serial_avail_o,
	output logic [7:0] serial_data_o,
	output logic       full_o
);

	logic [7:0]                mem [2**fifo_addr_bits];
	logic [fifo_addr_bits-1:0] wr_ptr, rd_ptr;
	logic [2:0]                strobe_sync;
	logic                      strobe_rise;
	logic                      push;

	assign serial_avail_o = (rd_ptr != wr_ptr);
	assign serial_data_o  = mem[rd_ptr];
	// one slot stays free to tell full from empty
	assign full_o         = (rd_ptr == wr_ptr + 1'b1);

	assign strobe_rise = strobe_sync[1] & ~strobe_sync[2];
	assign push        = wr_i.valid && wr_i.addr == UDR && !full_o;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			strobe_sync <= 3'b000;
		end else begin
			strobe_sync <= {strobe_sync[1:0], serial_strobe_i};
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (strobe_rise && serial_avail_o) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_i.data;
		end
	end

endmodule

/* hw/mfp.sv */
// 68901-style multi-function peripheral, top level
// cpu register port, four timers, vectored interrupts and uart transmit FIFO
`timescale 1ns/10ps

module mfp
	import mfp_pkg::*;
#(
	parameter int num_timers     = 4,
	parameter int fifo_addr_bits = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] din_i,
	input  logic       sel_i,
	input  logic [4:0] addr_i,
	input  logic       ds_i,
	input  logic       rw_i,
	output logic [7:0] dout_o,
	output logic       irq_o,
	input  logic       iack_i,
	output logic       serial_avail_o,
	input  logic       serial_strobe_i,
	output logic [7:0] serial_data_o,
	input  logic       clk_ext_i,
	input  logic [3:0] timer_in_i,
	input  logic       dma_irq_i,
	input  logic       acia_irq_i,
	input  logic       blitter_irq_i,
	input  logic       mono_detect_i
);

	mfp_wr_t       wr;
	mfp_irq_regs_t irq_regs;
	logic [7:0]    irq_vec;
	logic          fifo_full;

	mfp_timer_if tmr_if [num_timers] ();

	mfp_regs #(
		.num_timers (num_timers)
	) u_regs (
		.clk         (clk),
		.reset       (reset),
		.din_i       (din_i),
		.sel_i       (sel_i),
		.addr_i      (addr_i),
		.ds_i        (ds_i),
		.rw_i        (rw_i),
		.iack_i      (iack_i),
		.dout_o      (dout_o),
		.wr_o        (wr),
		.timers      (tmr_if),
		.irq_regs_i  (irq_regs),
		.irq_vec_i   (irq_vec),
		.fifo_full_i (fifo_full)
	);

	// timers A to D, each with its own event input
	for (genvar i = 0; i < num_timers; i++) begin : g_timer
		mfp_timer u_timer (
			.clk       (clk),
			.reset     (reset),
			.clk_ext_i (clk_ext_i),
			.event_i   (timer_in_i[i]),
			.tmr       (tmr_if[i])
		);
	end

	mfp_irq_ctrl #(
		.num_timers (num_timers)
	) u_irq_ctrl (
		.clk           (clk),
		.reset         (reset),
		.wr_i          (wr),
		.timers        (tmr_if),
		.dma_irq_i     (dma_irq_i),
		.acia_irq_i    (acia_irq_i),
		.blitter_irq_i (blitter_irq_i),
		.mono_detect_i (mono_detect_i),
		.iack_i        (iack_i),
		.irq_regs_o    (irq_regs),
		.irq_vec_o     (irq_vec),
		.irq_o         (irq_o)
	);

	mfp_uart_fifo #(
		.fifo_addr_bits (fifo_addr_bits)
	) u_uart_fifo (
		.clk             (clk),
		.reset           (reset),
		.wr_i            (wr),
		.serial_strobe_i (serial_strobe_i),
		.serial_avail_o  (serial_avail_o),
		.serial_data_o   (serial_data_o),
		.full_o          (fifo_full)
	);

endmodule

/* sim/mfp_tb.sv */
// self-checking testbench for the MFP
// applies a table of bus, pin and acknowledge operations and checks each response
`timescale 1ns/10ps

module mfp_tb
	import mfp_pkg::*;
;

	typedef enum {OP_WRITE, OP_READ, OP_PULSE, OP_IACK, OP_STROBE, OP_WAIT_IRQ} op_e;

	// pin selectors for pulse entries, 0 to 3 are the timer event inputs
	localparam logic [4:0] pin_tmr_a = 5'd0;
	localparam logic [4:0] pin_tmr_b = 5'd1;
	localparam logic [4:0] pin_dma   = 5'd4;

	localparam int       evt_count  = 5;
	localparam int       ext_period = 4;
	localparam int       tddr_value = 3;
	localparam int       delay_div  = 4;
	localparam logic     mono_level = 1'b1;
	// no expiry before the 12th prescaled edge, allow for edge alignment and sync
	localparam int delay_low    = (tddr_value * delay_div - 1) * ext_period - ext_period;
	localparam int delay_window = 3 * ext_period + 4;

	logic       clk = 1'b0;
	logic       reset;
	logic [7:0] din_i;
	logic       sel_i;
	logic [4:0] addr_i;
	logic       ds_i;
	logic       rw_i;
	logic [7:0] dout_o;
	logic       irq_o;
	logic       iack_i;
	logic       serial_avail_o;
	logic       serial_strobe_i;
	logic [7:0] serial_data_o;
	logic       clk_ext_i;
	logic [3:0] timer_in_i;
	logic       dma_irq_i;
	logic       acia_irq_i;
	logic       blitter_irq_i;
	logic       mono_detect_i;

	// stimulus table, one column per queue
	string      names [$];
	op_e        ops [$];
	logic [4:0] addrs [$];
	logic [7:0] datas [$];
	logic [7:0] exps [$];

	int seed        = 32'h28410af4;
	int error_count = 0;
	int test_count  = 0;
	int fail_tests  = 0;
	int cycle_count = 0;
	int cycle_limit = 1000;
	int ext_phase   = 0;

	mfp dut (
		.clk             (clk),
		.reset           (reset),
		.din_i           (din_i),
		.sel_i           (sel_i),
		.addr_i          (addr_i),
		.ds_i            (ds_i),
		.rw_i            (rw_i),
		.dout_o          (dout_o),
		.irq_o           (irq_o),
		.iack_i          (iack_i),
		.serial_avail_o  (serial_avail_o),
		.serial_strobe_i (serial_strobe_i),
		.serial_data_o   (serial_data_o),
		.clk_ext_i       (clk_ext_i),
		.timer_in_i      (timer_in_i),
		.dma_irq_i       (dma_irq_i),
		.acia_irq_i      (acia_irq_i),
		.blitter_irq_i   (blitter_irq_i),
		.mono_detect_i   (mono_detect_i)
	);

	always #20 clk = ~clk;

	// external timer clock, one toggle every two clk cycles
	always begin
		@(posedge clk);
		#2;
		if (ext_phase == 1) begin
			clk_ext_i = ~clk_ext_i;
			ext_phase = 0;
		end else begin
			ext_phase = 1;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected 8'h%02h, actual 8'h%02h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
			error_count++;
		end
	endtask

	// inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic bus_write(input logic [4:0] addr, input logic [7:0] data);
		sel_i  = 1'b1;
		ds_i   = 1'b0;
		rw_i   = 1'b0;
		addr_i = addr;
		din_i  = data;
		next_cycle();
		sel_i = 1'b0;
		ds_i  = 1'b1;
		rw_i  = 1'b1;
	endtask

	task automatic bus_read(input logic [4:0] addr, output logic [7:0] data);
		sel_i  = 1'b1;
		ds_i   = 1'b0;
		rw_i   = 1'b1;
		addr_i = addr;
		@(negedge clk);
		data = dout_o;
		next_cycle();
		sel_i = 1'b0;
		ds_i  = 1'b1;
	endtask

	// one-cycle acknowledge, then time for the controller to see the edge
	task automatic iack_cycle(output logic [7:0] vec);
		iack_i = 1'b1;
		@(negedge clk);
		vec = dout_o;
		next_cycle();
		iack_i = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic drive_pin(input logic [4:0] pin, input logic level);
		if (pin == pin_dma) begin
			dma_irq_i = level;
		end else begin
			timer_in_i[pin[1:0]] = level;
		end
	endtask

	task automatic pulse_pin(input logic [4:0] pin, input int count);
		repeat (count) begin
			drive_pin(pin, 1'b1);
			next_cycle();
			next_cycle();
			drive_pin(pin, 1'b0);
			next_cycle();
			next_cycle();
		end
		next_cycle();
		next_cycle();
	endtask

	task automatic strobe_check(input string name, input logic avail, input logic [7:0] data);
		@(negedge clk);
		check_bit(name, avail, serial_avail_o);
		if (avail) begin
			check_byte(name, data, serial_data_o);
		end
		next_cycle();
		serial_strobe_i = 1'b1;
		next_cycle();
		next_cycle();
		serial_strobe_i = 1'b0;
		repeat (3) next_cycle();
	endtask

	// high: irq_o must rise within bound cycles, low: it must stay low for bound cycles
	task automatic wait_irq(input string name, input logic want_high, input int bound);
		logic seen;
		seen = 1'b0;
		for (int c = 0; c < bound; c++) begin
			@(negedge clk);
			if (irq_o && !seen) begin
				seen = 1'b1;
				if (!want_high) begin
					check_bit(name, 1'b0, irq_o);
				end
			end
			next_cycle();
			if (seen && want_high) begin
				break;
			end
		end
		if (want_high && !seen) begin
			$display("%s: irq_o did not rise within %0d cycles", name, bound);
			error_count++;
		end
	endtask

	function automatic void add_entry(input string name, input op_e op, input logic [4:0] addr,
			input logic [7:0] data, input logic [7:0] exp);
		names.push_back(name);
		ops.push_back(op);
		addrs.push_back(addr);
		datas.push_back(data);
		exps.push_back(exp);
	endfunction

	function automatic void readback_pair(input string tag, input logic [4:0] addr);
		logic [7:0] v;
		v = 8'($random(seed));
		add_entry({tag, "_write"}, OP_WRITE, addr, v, 8'h00);
		add_entry({tag, "_read"}, OP_READ, addr, 8'h00, v);
	endfunction

	function automatic int op_cycles(input op_e op, input logic [7:0] data);
		case (op)
			OP_PULSE:    return 4 * int'(data) + 2;
			OP_STROBE:   return 6;
			OP_IACK:     return 3;
			OP_WAIT_IRQ: return int'(data);
			default:     return 1;
		endcase
	endfunction

	function automatic void build_table();
		logic [7:0] fifo_bytes [18];
		// register readback
		readback_pair("vr", VR);
		readback_pair("aer", AER);
		readback_pair("ddr", DDR);
		readback_pair("iera", IERA);
		readback_pair("imrb", IMRB);
		readback_pair("tadr", TADR);
		add_entry("ipra_zero", OP_READ, IPRA, 8'h00, 8'h00);
		add_entry("iprb_zero", OP_READ, IPRB, 8'h00, 8'h00);
		add_entry("iera_clear", OP_WRITE, IERA, 8'h00, 8'h00);
		add_entry("imrb_clear", OP_WRITE, IMRB, 8'h00, 8'h00);
		add_entry("aer_clear", OP_WRITE, AER, 8'h00, 8'h00);
		add_entry("ddr_clear", OP_WRITE, DDR, 8'h00, 8'h00);
		add_entry("vr_clear", OP_WRITE, VR, 8'h00, 8'h00);
		// timer B counts event edges, source 8 is bit 0 of the A registers
		add_entry("tbdr_load", OP_WRITE, TBDR, 8'(evt_count), 8'h00);
		add_entry("tbcr_event", OP_WRITE, TBCR, 8'(EVENT), 8'h00);
		add_entry("iera_tb", OP_WRITE, IERA, 8'h01, 8'h00);
		add_entry("imra_tb", OP_WRITE, IMRA, 8'h01, 8'h00);
		add_entry("vr_base", OP_WRITE, VR, 8'h40, 8'h00);
		add_entry("events_short", OP_PULSE, pin_tmr_b, 8'(evt_count - 1), 8'h00);
		add_entry("irq_low_before_nth", OP_WAIT_IRQ, 5'd0, 8'd8, 8'h00);
		add_entry("event_nth", OP_PULSE, pin_tmr_b, 8'd1, 8'h00);
		add_entry("irq_after_nth", OP_WAIT_IRQ, 5'd0, 8'd8, 8'h01);
		add_entry("vector_timer_b", OP_IACK, 5'd0, 8'h00, 8'h48);
		// timers A and B pending at once, in-service mode on
		add_entry("vr_sei", OP_WRITE, VR, 8'h48, 8'h00);
		add_entry("iera_ab", OP_WRITE, IERA, 8'h21, 8'h00);
		add_entry("imra_ab", OP_WRITE, IMRA, 8'h21, 8'h00);
		add_entry("tadr_one", OP_WRITE, TADR, 8'h01, 8'h00);
		add_entry("tacr_event", OP_WRITE, TACR, 8'(EVENT), 8'h00);
		add_entry("events_b", OP_PULSE, pin_tmr_b, 8'(evt_count), 8'h00);
		add_entry("event_a", OP_PULSE, pin_tmr_a, 8'd1, 8'h00);
		add_entry("both_pending", OP_READ, IPRA, 8'h00, 8'h21);
		add_entry("vector_timer_a", OP_IACK, 5'd0, 8'h00, 8'h4D);
		add_entry("isra_timer_a", OP_READ, ISRA, 8'h00, 8'h20);
		add_entry("irq_held_by_isr", OP_WAIT_IRQ, 5'd0, 8'd10, 8'h00);
		add_entry("isra_release", OP_WRITE, ISRA, 8'h00, 8'h00);
		add_entry("irq_after_isr_clear", OP_WAIT_IRQ, 5'd0, 8'd8, 8'h01);
		add_entry("vector_timer_b_again", OP_IACK, 5'd0, 8'h00, 8'h48);
		add_entry("isra_timer_b", OP_READ, ISRA, 8'h00, 8'h01);
		add_entry("isra_clear", OP_WRITE, ISRA, 8'h00, 8'h00);
		add_entry("tacr_stop", OP_WRITE, TACR, 8'(STOP), 8'h00);
		add_entry("tbcr_stop", OP_WRITE, TBCR, 8'(STOP), 8'h00);
		// dma line on port bit 5, source 7
		add_entry("ierb_dma", OP_WRITE, IERB, 8'h80, 8'h00);
		add_entry("imrb_dma", OP_WRITE, IMRB, 8'h80, 8'h00);
		add_entry("dma_edge", OP_PULSE, pin_dma, 8'd1, 8'h00);
		add_entry("iprb_dma", OP_READ, IPRB, 8'h00, 8'h80);
		add_entry("irq_dma", OP_WAIT_IRQ, 5'd0, 8'd4, 8'h01);
		add_entry("imrb_mask", OP_WRITE, IMRB, 8'h00, 8'h00);
		add_entry("irq_masked_dma", OP_WAIT_IRQ, 5'd0, 8'd8, 8'h00);
		add_entry("dma_still_pending", OP_READ, IPRB, 8'h00, 8'h80);
		// idle low peripheral lines read as ones on the port
		add_entry("gpip_mono", OP_READ, GPIP, 8'h00, {mono_level, 1'b0, 3'b111, 3'b000});
		add_entry("iprb_clear", OP_WRITE, IPRB, 8'h00, 8'h00);
		add_entry("ierb_clear", OP_WRITE, IERB, 8'h00, 8'h00);
		// uart transmit FIFO
		for (int i = 0; i < 18; i++) begin
			fifo_bytes[i] = 8'($random(seed));
		end
		for (int i = 0; i < 3; i++) begin
			add_entry("udr_write", OP_WRITE, UDR, fifo_bytes[i], 8'h00);
		end
		for (int i = 0; i < 3; i++) begin
			add_entry("fifo_byte", OP_STROBE, 5'd0, 8'h01, fifo_bytes[i]);
		end
		add_entry("fifo_empty", OP_STROBE, 5'd0, 8'h00, 8'h00);
		for (int i = 3; i < 18; i++) begin
			add_entry("udr_fill", OP_WRITE, UDR, fifo_bytes[i], 8'h00);
		end
		add_entry("udr_dropped", OP_WRITE, UDR, 8'($random(seed)), 8'h00);
		add_entry("tsr_full", OP_READ, TSR, 8'h00, 8'h00);
		add_entry("fifo_first", OP_STROBE, 5'd0, 8'h01, fifo_bytes[3]);
		add_entry("tsr_space", OP_READ, TSR, 8'h00, 8'h80);
		for (int i = 4; i < 18; i++) begin
			add_entry("fifo_drain", OP_STROBE, 5'd0, 8'h01, fifo_bytes[i]);
		end
		add_entry("fifo_drained", OP_STROBE, 5'd0, 8'h00, 8'h00);
		// timer D in delay mode, source 4
		add_entry("tddr_load", OP_WRITE, TDDR, 8'(tddr_value), 8'h00);
		add_entry("ierb_td", OP_WRITE, IERB, 8'h10, 8'h00);
		add_entry("imrb_td", OP_WRITE, IMRB, 8'h10, 8'h00);
		add_entry("tcdcr_delay4", OP_WRITE, TCDCR, 8'(DELAY_4), 8'h00);
		add_entry("irq_low_early", OP_WAIT_IRQ, 5'd0, 8'(delay_low), 8'h00);
		add_entry("irq_delay", OP_WAIT_IRQ, 5'd0, 8'(delay_window), 8'h01);
		add_entry("tcdcr_stop", OP_WRITE, TCDCR, 8'h00, 8'h00);
	endfunction

	task automatic run_entry(input int idx);
		logic [7:0] got;
		int         errors_before;
		errors_before = error_count;
		case (ops[idx])
			OP_WRITE: bus_write(addrs[idx], datas[idx]);
			OP_READ: begin
				bus_read(addrs[idx], got);
				check_byte(names[idx], exps[idx], got);
			end
			OP_PULSE:    pulse_pin(addrs[idx], int'(datas[idx]));
			OP_IACK: begin
				iack_cycle(got);
				check_byte(names[idx], exps[idx], got);
			end
			OP_STROBE:   strobe_check(names[idx], datas[idx][0], exps[idx]);
			OP_WAIT_IRQ: wait_irq(names[idx], exps[idx][0], int'(datas[idx]));
			default:     ;
		endcase
		test_count++;
		if (error_count == errors_before) begin
			$display("test %-22s ok", names[idx]);
		end else begin
			fail_tests++;
			$display("test %-22s failed", names[idx]);
		end
	endtask

	initial begin
		reset           = 1'b1;
		din_i           = 8'h00;
		sel_i           = 1'b0;
		addr_i          = 5'd0;
		ds_i            = 1'b1;
		rw_i            = 1'b1;
		iack_i          = 1'b0;
		serial_strobe_i = 1'b0;
		clk_ext_i       = 1'b0;
		timer_in_i      = 4'h0;
		dma_irq_i       = 1'b0;
		acia_irq_i      = 1'b0;
		blitter_irq_i   = 1'b0;
		mono_detect_i   = mono_level;
		build_table();
		cycle_limit = 200;
		for (int i = 0; i < ops.size(); i++) begin
			cycle_limit += op_cycles(ops[i], datas[i]);
		end
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		next_cycle();
		for (int i = 0; i < ops.size(); i++) begin
			run_entry(i);
		end
		$display("%0d tests run, %0d failed, %0d check errors", test_count, fail_tests,
			error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* mfp.f */
common/mfp_pkg.sv
common/mfp_timer_if.sv
hw/mfp_regs.sv
hw/mfp_timer/mfp_timer.sv
hw/mfp_irq_ctrl.sv
hw/mfp_uart_fifo.sv
hw/mfp.sv
sim/mfp_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the MFP testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module mfp_tb -f mfp.f -o mfp_sim
output=$(./obj_dir/mfp_sim)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "ALL CHECKS PASSED"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
